// ==== Bender.yml ====
package:
  name: cwreg

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cwreg_pkg.sv
      - hw/reg_bus_if.sv
      - hw/usb_reg_bridge.sv
      - hw/reg_block.sv
      - hw/reg_read_combine.sv
      - hw/cwreg_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/cwreg_props.sv
      - dv/cwreg_tb.sv

// ==== dv/cwreg_cases.txt ====
# Columns: name op addr byte0 byte1 byte2 byte3 [len], all numbers in hex
# op wr writes the four bytes; op rd expects the four bytes and then the register length
reset_b0_r0 rd 00 00 00 00 00 4
reset_b1_r1 rd 09 00 00 00 00 4
reset_b2_r6 rd 16 00 00 00 00 4
reset_b3_r6 rd 1e 00 00 00 00 4
wr_b0_r0 wr 00 11 22 33 44
wr_b1_r0 wr 08 55 66 77 88
wr_b2_r3 wr 13 de ad be ef
wr_b3_r6 wr 1e 01 02 03 04
wr_b0_r3 wr 03 a5 5a c3 3c
rd_b0_r0 rd 00 11 22 33 44 4
rd_b1_r0 rd 08 55 66 77 88 4
rd_b2_r3 rd 13 de ad be ef 4
rd_b3_r6 rd 1e 01 02 03 04 4
rd_b0_r3 rd 03 a5 5a c3 3c 4
iso_b1_r3 rd 0b 00 00 00 00 4
iso_b3_r3 rd 1b 00 00 00 00 4
iso_b2_r0 rd 10 00 00 00 00 4
id_b0 rd 07 a0 00 00 00 1
id_b1 rd 0f a1 00 00 00 1
id_b2 rd 17 a2 00 00 00 1
id_b3 rd 1f a3 00 00 00 1
idwr_b2 wr 17 ff ff ff ff
id_b2_after rd 17 a2 00 00 00 1
unmap_20 rd 20 00 00 00 00 0
unmap_3f rd 3f 00 00 00 00 0
unmap_wr_2a wr 2a 99 99 99 99
unmap_2a rd 2a 00 00 00 00 0
unmap_b0_r2 rd 02 00 00 00 00 4
unmap_b1_r2 rd 0a 00 00 00 00 4
rewr_b0_r0 wr 00 c0 ff ee 42
reread_b0_r0 rd 00 c0 ff ee 42 4
reread_b1_r0 rd 08 55 66 77 88 4

// ==== dv/cwreg_props.sv ====
// Assertions on the bridge pulses and the data output enable that get bound into the bridge and combiner
`timescale 1ns/100ps

module cwreg_props #(
	parameter bit CHECK_PULSES = 1'b1,
	parameter bit CHECK_DOE    = 1'b1
) (
	input logic clk_usb,
	input logic reset_i,
	input logic read_i,
	input logic write_i,
	input logic ce_n_i,
	input logic doe_i
);

	if (CHECK_PULSES) begin : g_pulses
		// Pulses last exactly one cycle
		a_read_single: assert property (@(posedge clk_usb) disable iff (reset_i)
			read_i |=> !read_i)
			else $error("read pulse lasted more than one cycle");

		a_write_single: assert property (@(posedge clk_usb) disable iff (reset_i)
			write_i |=> !write_i)
			else $error("write pulse lasted more than one cycle");

		a_pulses_reset: assert property (@(posedge clk_usb)
			reset_i |=> !read_i && !write_i)
			else $error("read or write pulse high right after reset");
	end

	if (CHECK_DOE) begin : g_doe
		// Output enable lags CE by one cycle
		a_doe_ce: assert property (@(posedge clk_usb) disable iff (reset_i)
			$past(ce_n_i) |-> !doe_i)
			else $error("output enable high although CE was high on the previous cycle");

		a_doe_reset: assert property (@(posedge clk_usb)
			reset_i |=> !doe_i)
			else $error("output enable high right after reset");
	end

endmodule

// Pulse checks only in the bridge
bind usb_reg_bridge cwreg_props #(
	.CHECK_PULSES (1'b1),
	.CHECK_DOE    (1'b0)
) cwreg_props_bridge_inst (
	.clk_usb (clk_usb),
	.reset_i (reset_i),
	.read_i  (read_q),
	.write_i (write_q),
	.ce_n_i  (1'b1),
	.doe_i   (1'b0)
);

// Output enable checks only in the combiner
bind reg_read_combine cwreg_props #(
	.CHECK_PULSES (1'b0),
	.CHECK_DOE    (1'b1)
) cwreg_props_combine_inst (
	.clk_usb (clk_usb),
	.reset_i (reset_i),
	.read_i  (1'b0),
	.write_i (1'b0),
	.ce_n_i  (usb_ce_n_i),
	.doe_i   (usb_doe_o)
);

// ==== dv/cwreg_tb.sv ====
// Testbench for the register path top level, replays the host bus cycles listed in dv/cwreg_cases.txt
`timescale 1ns/100ps
`include "cwreg_config.svh"

module cwreg_tb;

	localparam int  RESET_CYCLES    = 10;
	localparam int  CYCLES_PER_CASE = 40; // Address cycle plus four strobes take about 30
	localparam time DRIVE_DLY       = 10ns;

	logic                     clk_usb = 1'b0;
	logic                     reset_i;
	logic [`CWREG_ADDR_W-1:0] usb_addr_i;
	logic [`CWREG_DATA_W-1:0] usb_din_i;
	logic                     usb_rd_n_i;
	logic                     usb_wr_n_i;
	logic                     usb_ce_n_i;
	logic                     usb_ale_n_i;
	cwreg_pkg::byte_t         usb_dout_o;
	logic                     usb_doe_o;
	cwreg_pkg::hyplen_t       usb_hyplen_o;

	// Cases from the file, bytes packed with byte 0 lowest
	string                                         case_name[$];
	string                                         case_op[$];
	logic [`CWREG_ADDR_W-1:0]                      case_addr[$];
	logic [`CWREG_REG_BYTES*`CWREG_DATA_W-1:0]     case_bytes[$];
	cwreg_pkg::hyplen_t                            case_len[$];

	int byte_errors   = 0;
	int hyplen_errors = 0;
	int doe_errors    = 0;
	int other_errors  = 0;
	int cycle_cnt     = 0;
	int cycle_limit   = 0; // Set once the cases are loaded

	always #50 clk_usb = ~clk_usb;

	cwreg_top cwreg_top_inst (
		.clk_usb      (clk_usb),
		.reset_i      (reset_i),
		.usb_addr_i   (usb_addr_i),
		.usb_din_i    (usb_din_i),
		.usb_rd_n_i   (usb_rd_n_i),
		.usb_wr_n_i   (usb_wr_n_i),
		.usb_ce_n_i   (usb_ce_n_i),
		.usb_ale_n_i  (usb_ale_n_i),
		.usb_dout_o   (usb_dout_o),
		.usb_doe_o    (usb_doe_o),
		.usb_hyplen_o (usb_hyplen_o)
	);

	always @(posedge clk_usb) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic check_byte(input string name, input cwreg_pkg::byte_t exp,
			input cwreg_pkg::byte_t act);
		if (act !== exp) begin
			byte_errors++;
			$display("[ERROR] %s: read byte expected %02h, actual %02h", name, exp, act);
		end
	endtask

	task automatic check_hyplen(input string name, input cwreg_pkg::hyplen_t exp,
			input cwreg_pkg::hyplen_t act);
		if (act !== exp) begin
			hyplen_errors++;
			$display("[ERROR] %s: length expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_doe(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			doe_errors++;
			$display("[ERROR] %s: output enable expected %b, actual %b", name, exp, act);
		end
	endtask

	// Lands 10 ns after the next rising edge, where inputs change
	task automatic next_cycle();
		@(posedge clk_usb);
		#DRIVE_DLY;
	endtask

	task automatic load_cases();
		int    fd;
		int    n;
		int    c;
		int    addr;
		int    b0;
		int    b1;
		int    b2;
		int    b3;
		int    len;
		string tok;
		string op;
		fd = $fopen("dv/cwreg_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the cases file dv/cwreg_cases.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1)
				break;
			if (tok.substr(0, 0) == "#") begin // Comment runs to end of line
				c = $fgetc(fd);
				while (c != 10 && c != -1)
					c = $fgetc(fd);
				continue;
			end
			n = $fscanf(fd, "%s %h %h %h %h %h", op, addr, b0, b1, b2, b3);
			len = 0;
			if (op == "rd")
				n += $fscanf(fd, "%h", len);
			if ((op != "rd" && op != "wr") || n != ((op == "rd") ? 7 : 6)) begin
				$display("Malformed line in the cases file for case %s", tok);
				other_errors++;
				break;
			end
			case_name.push_back(tok);
			case_op.push_back(op);
			case_addr.push_back(addr[`CWREG_ADDR_W-1:0]);
			case_bytes.push_back({b3[7:0], b2[7:0], b1[7:0], b0[7:0]});
			case_len.push_back(cwreg_pkg::hyplen_t'(len));
		end
		$fclose(fd);
		if (case_name.size() == 0) begin
			$display("The cases file holds no transactions");
			other_errors++;
		end
	endtask

	// ALE low for four cycles, then two idle cycles
	task automatic address_cycle(input logic [`CWREG_ADDR_W-1:0] addr);
		usb_addr_i  = addr;
		usb_ce_n_i  = 1'b0;
		usb_ale_n_i = 1'b0;
		repeat (4) next_cycle();
		usb_ale_n_i = 1'b1;
		usb_ce_n_i  = 1'b1;
		repeat (2) next_cycle();
	endtask

	task automatic write_strobe(input string name, input cwreg_pkg::byte_t data);
		usb_din_i  = data;
		usb_ce_n_i = 1'b0;
		usb_wr_n_i = 1'b0;
		repeat (2) next_cycle();
		check_doe(name, 1'b0, usb_doe_o); // Mid-strobe, clear of the edges
		repeat (2) next_cycle();
		usb_wr_n_i = 1'b1;
		usb_ce_n_i = 1'b1;
		repeat (2) next_cycle();
	endtask

	task automatic read_strobe(input string name, input cwreg_pkg::byte_t exp);
		usb_ce_n_i = 1'b0;
		usb_rd_n_i = 1'b0;
		repeat (2) next_cycle();
		check_doe(name, 1'b1, usb_doe_o);
		repeat (2) next_cycle();
		check_byte(name, exp, usb_dout_o); // Last cycle of the strobe
		usb_rd_n_i = 1'b1;
		usb_ce_n_i = 1'b1;
		repeat (2) next_cycle();
	endtask

	task automatic run_case(input int idx);
		string            tag;
		cwreg_pkg::byte_t exp;
		address_cycle(case_addr[idx]);
		check_doe({case_name[idx], " idle"}, 1'b0, usb_doe_o);
		if (case_op[idx] == "rd")
			check_hyplen(case_name[idx], case_len[idx], usb_hyplen_o);
		for (int i = 0; i < `CWREG_REG_BYTES; i++) begin
			tag = $sformatf("%s byte %0d", case_name[idx], i);
			exp = case_bytes[idx][i*`CWREG_DATA_W +: `CWREG_DATA_W];
			if (case_op[idx] == "wr")
				write_strobe(tag, exp);
			else
				read_strobe(tag, exp);
		end
	endtask

	initial begin
		int total;
		reset_i     = 1'b1;
		usb_addr_i  = '0;
		usb_din_i   = '0;
		usb_rd_n_i  = 1'b1;
		usb_wr_n_i  = 1'b1;
		usb_ce_n_i  = 1'b1;
		usb_ale_n_i = 1'b1;
		load_cases();
		cycle_limit = CYCLES_PER_CASE * case_name.size() + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk_usb);
		#DRIVE_DLY;
		reset_i = 1'b0;
		repeat (2) next_cycle();
		check_doe("after reset", 1'b0, usb_doe_o);
		check_hyplen("after reset", '0, usb_hyplen_o); // No address latched yet
		foreach (case_name[i])
			run_case(i);
		total = byte_errors + hyplen_errors + doe_errors + other_errors;
		$display("Errors: byte %0d, length %0d, output enable %0d, other %0d",
			byte_errors, hyplen_errors, doe_errors, other_errors);
		if (total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== hw/cwreg_config.svh ====
// Bus widths and register map sizes, included by every RTL file that needs them
`ifndef CWREG_CONFIG_SVH
`define CWREG_CONFIG_SVH

// Register address from the USB chip
`define CWREG_ADDR_W 6

// Host data byte
`define CWREG_DATA_W 8

// Byte index within a register, also used for register lengths
`define CWREG_BCNT_W 16

// Register blocks on the internal bus
`define CWREG_NUM_BLOCKS 4

// Address window of each block, last slot is the ID register
`define CWREG_REGS_PER_BLOCK 8

`define CWREG_REG_BYTES 4 // Writable register size

// ID byte of block 0, later blocks count up
`define CWREG_ID_BASE 8'hA0

`endif

// ==== hw/cwreg_pkg.sv ====
// Register bus response types shared by the blocks, the read combiner and the testbench
`include "cwreg_config.svh"

package cwreg_pkg;

	// Register length in bytes, as reported back to the host
	typedef logic [`CWREG_BCNT_W-1:0] hyplen_t;

	// Host data byte
	typedef logic [`CWREG_DATA_W-1:0] byte_t;

	// One block's answer for the current address and byte index.
	// A block that does not own the address returns all zeros, so the
	// answers of all blocks can simply be ORed together.
	typedef struct packed {
		byte_t   data;   // Selected register byte
		hyplen_t hyplen; // Length of the addressed register
	} reg_resp_t;

endpackage

// ==== hw/cwreg_top.sv ====
// Register path top level, wrapped by the board top which owns the bidirectional data pads
`timescale 1ns/100ps
`include "cwreg_config.svh"

module cwreg_top (
	input  logic                     clk_usb,
	input  logic                     reset_i,
	input  logic [`CWREG_ADDR_W-1:0] usb_addr_i,
	input  logic [`CWREG_DATA_W-1:0] usb_din_i,
	input  logic                     usb_rd_n_i,
	input  logic                     usb_wr_n_i,
	input  logic                     usb_ce_n_i,
	input  logic                     usb_ale_n_i,
	output logic [`CWREG_DATA_W-1:0] usb_dout_o,
	output logic                     usb_doe_o,
	output cwreg_pkg::hyplen_t       usb_hyplen_o
);

	reg_bus_if reg_bus ();

	// One response per block, merged in the combiner
	cwreg_pkg::reg_resp_t resp [`CWREG_NUM_BLOCKS];

	usb_reg_bridge usb_reg_bridge_inst (
		.clk_usb     (clk_usb),
		.reset_i     (reset_i),
		.usb_addr_i  (usb_addr_i),
		.usb_din_i   (usb_din_i),
		.usb_rd_n_i  (usb_rd_n_i),
		.usb_wr_n_i  (usb_wr_n_i),
		.usb_ce_n_i  (usb_ce_n_i),
		.usb_ale_n_i (usb_ale_n_i),
		.bus         (reg_bus.master)
	);

	for (genvar g = 0; g < `CWREG_NUM_BLOCKS; g++) begin : g_block
		reg_block #(
			.BLOCK_INDEX (g)
		) reg_block_inst (
			.clk_usb (clk_usb),
			.reset_i (reset_i),
			.bus     (reg_bus.block),
			.resp_o  (resp[g])
		);
	end

	reg_read_combine reg_read_combine_inst (
		.clk_usb      (clk_usb),
		.reset_i      (reset_i),
		.resp_i       (resp),
		.usb_rd_n_i   (usb_rd_n_i),
		.usb_ce_n_i   (usb_ce_n_i),
		.usb_dout_o   (usb_dout_o),
		.usb_doe_o    (usb_doe_o),
		.usb_hyplen_o (usb_hyplen_o)
	);

endmodule

// ==== hw/reg_block.sv ====
// One address window of byte-addressed registers plus an ID register, instantiated per block index
`timescale 1ns/100ps
`include "cwreg_config.svh"

module reg_block #(
	parameter int BLOCK_INDEX = 0
) (
	input  logic                  clk_usb,
	input  logic                  reset_i,
	reg_bus_if.block              bus,
	output cwreg_pkg::reg_resp_t  resp_o
);

	localparam int OFS_W  = $clog2(`CWREG_REGS_PER_BLOCK);
	localparam int WIN_W  = `CWREG_ADDR_W - OFS_W;
	localparam int BSEL_W = $clog2(`CWREG_REG_BYTES);
	localparam int NUM_WR = `CWREG_REGS_PER_BLOCK - 1; // Writable registers

	localparam logic [WIN_W-1:0] WIN_SEL = WIN_W'(BLOCK_INDEX);
	localparam logic [OFS_W-1:0] ID_OFS  = OFS_W'(`CWREG_REGS_PER_BLOCK - 1);
	localparam logic [`CWREG_DATA_W-1:0] ID_BYTE =
		`CWREG_DATA_W'(`CWREG_ID_BASE + BLOCK_INDEX);

	logic [`CWREG_REG_BYTES-1:0][`CWREG_DATA_W-1:0] regs_q [NUM_WR];

	logic              win_hit;
	logic [OFS_W-1:0]  reg_ofs;
	logic [BSEL_W-1:0] byte_sel;
	logic              byte_ok;
	logic              is_id;

	// Upper address bits pick the block, lower bits the register
	assign reg_ofs = bus.address[OFS_W-1:0];
	assign win_hit = bus.addrvalid &&
		(bus.address[`CWREG_ADDR_W-1:OFS_W] == WIN_SEL);
	assign is_id   = (reg_ofs == ID_OFS);

	assign byte_sel = bus.bytecnt[BSEL_W-1:0];
	assign byte_ok  = (bus.bytecnt < `CWREG_BCNT_W'(`CWREG_REG_BYTES));

	always_ff @(posedge clk_usb) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_WR; i++)
				regs_q[i] <= '0;
		end else if (bus.write && win_hit && !is_id && byte_ok) begin
			regs_q[reg_ofs][byte_sel] <= bus.wdata; // ID register ignores writes
		end
	end

	// Response for the current address and byte, zero when not ours
	always_comb begin
		resp_o = '0;
		if (win_hit) begin
			if (is_id) begin
				resp_o.hyplen = cwreg_pkg::hyplen_t'(1);
				if (bus.bytecnt == '0)
					resp_o.data = ID_BYTE;
			end else begin
				resp_o.hyplen = cwreg_pkg::hyplen_t'(`CWREG_REG_BYTES);
				if (byte_ok)
					resp_o.data = regs_q[reg_ofs][byte_sel];
			end
		end
	end

endmodule

// ==== hw/reg_bus_if.sv ====
// Internal register bus from the USB bridge to the register blocks
`timescale 1ns/100ps
`include "cwreg_config.svh"

interface reg_bus_if;

	logic [`CWREG_ADDR_W-1:0] address;   // Latched register address
	logic [`CWREG_BCNT_W-1:0] bytecnt;   // Byte index within the register
	logic [`CWREG_DATA_W-1:0] wdata;     // Host write byte
	logic                     read;      // One-cycle read pulse
	logic                     write;     // One-cycle write pulse
	logic                     addrvalid; // Address latched since reset

	// Bridge side
	modport master (
		output address,
		output bytecnt,
		output wdata,
		output read,
		output write,
		output addrvalid
	);

	// Register block side
	modport block (
		input address,
		input bytecnt,
		input wdata,
		input read,
		input write,
		input addrvalid
	);

endinterface

// ==== hw/reg_read_combine.sv ====
// Merges the block responses by OR and registers the host read byte, length and output enable
`timescale 1ns/100ps
`include "cwreg_config.svh"

module reg_read_combine (
	input  logic                     clk_usb,
	input  logic                     reset_i,
	input  cwreg_pkg::reg_resp_t     resp_i [`CWREG_NUM_BLOCKS],
	input  logic                     usb_rd_n_i,
	input  logic                     usb_ce_n_i,
	output logic [`CWREG_DATA_W-1:0] usb_dout_o,
	output logic                     usb_doe_o,
	output cwreg_pkg::hyplen_t       usb_hyplen_o
);

	cwreg_pkg::byte_t   data_or;
	cwreg_pkg::hyplen_t hyplen_or;

	// Only the owning block drives nonzero, unmapped addresses give zero
	always_comb begin
		data_or   = '0;
		hyplen_or = '0;
		for (int i = 0; i < `CWREG_NUM_BLOCKS; i++) begin
			data_or   = data_or | resp_i[i].data;
			hyplen_or = hyplen_or | resp_i[i].hyplen;
		end
	end

	always_ff @(posedge clk_usb) begin
		if (reset_i) begin
			usb_dout_o   <= '0;
			usb_hyplen_o <= '0;
			usb_doe_o    <= 1'b0;
		end else begin
			usb_dout_o   <= data_or;
			usb_hyplen_o <= hyplen_or;
			usb_doe_o    <= ~usb_ce_n_i & ~usb_rd_n_i; // Pad drives only during a read
		end
	end

endmodule

// ==== hw/usb_reg_bridge.sv ====
// Turns the USB chip's parallel bus strobes into register bus pulses, address and byte count
`timescale 1ns/100ps
`include "cwreg_config.svh"

module usb_reg_bridge (
	input  logic                     clk_usb,
	input  logic                     reset_i,
	input  logic [`CWREG_ADDR_W-1:0] usb_addr_i,
	input  logic [`CWREG_DATA_W-1:0] usb_din_i,
	input  logic                     usb_rd_n_i,
	input  logic                     usb_wr_n_i,
	input  logic                     usb_ce_n_i,
	input  logic                     usb_ale_n_i,
	reg_bus_if.master                bus
);

	// Strobe levels qualified by chip enable
	logic rd_act;
	logic wr_act;
	logic ale_act;

	// Strobe levels seen on the previous edge
	logic rd_prev_q;
	logic wr_prev_q;

	logic rd_start;
	logic wr_start;
	logic strobe_end;

	logic [`CWREG_ADDR_W-1:0] address_q;
	logic [`CWREG_BCNT_W-1:0] bytecnt_q;
	logic [`CWREG_DATA_W-1:0] wdata_q;
	logic                     read_q;
	logic                     write_q;
	logic                     addrvalid_q;

	assign rd_act  = ~usb_ce_n_i & ~usb_rd_n_i;
	assign wr_act  = ~usb_ce_n_i & ~usb_wr_n_i;
	assign ale_act = ~usb_ce_n_i & ~usb_ale_n_i;

	assign rd_start = rd_act & ~rd_prev_q;
	assign wr_start = wr_act & ~wr_prev_q;

	// Either data strobe just went away
	assign strobe_end = (rd_prev_q & ~rd_act) | (wr_prev_q & ~wr_act);

	always_ff @(posedge clk_usb) begin
		if (reset_i) begin
			rd_prev_q   <= 1'b0;
			wr_prev_q   <= 1'b0;
			read_q      <= 1'b0;
			write_q     <= 1'b0;
			addrvalid_q <= 1'b0;
			bytecnt_q   <= '0;
		end else begin
			rd_prev_q <= rd_act;
			wr_prev_q <= wr_act;
			read_q    <= rd_start; // Single pulse per strobe
			write_q   <= wr_start;

			if (ale_act) begin
				addrvalid_q <= 1'b1;
				bytecnt_q   <= '0; // New address restarts the byte count
			end else if (strobe_end) begin
				bytecnt_q <= bytecnt_q + 1'b1;
			end
		end
	end

	// Address and write byte are plain payload
	always_ff @(posedge clk_usb) begin
		if (ale_act)
			address_q <= usb_addr_i;
		if (wr_start)
			wdata_q <= usb_din_i; // Lines up with the write pulse
	end

	assign bus.address   = address_q;
	assign bus.bytecnt   = bytecnt_q;
	assign bus.wdata     = wdata_q;
	assign bus.read      = read_q;
	assign bus.write     = write_q;
	assign bus.addrvalid = addrvalid_q;

endmodule

// ==== sources.f ====
+incdir+hw
hw/cwreg_pkg.sv
hw/reg_bus_if.sv
hw/usb_reg_bridge.sv
hw/reg_block.sv
hw/reg_read_combine.sv
hw/cwreg_top.sv
dv/cwreg_props.sv
dv/cwreg_tb.sv
